// ==== logic/axi4l_pkg.sv ====
// AXI4-Lite bus widths, response codes and payload structs; prot is carried but never checked.

package axi4l_pkg;

    // ------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------
    localparam int addr_bits = 12;          // byte address.
    localparam int data_bits = 32;
    localparam int strb_bits = data_bits / 8;
    localparam int resp_bits = 2;
    localparam int prot_bits = 3;

    // ------------------------------------------------------------
    // response codes
    // ------------------------------------------------------------
    localparam logic [resp_bits-1:0] resp_okay   = 2'd0;
    localparam logic [resp_bits-1:0] resp_slverr = 2'd2;

    // ------------------------------------------------------------
    // channel payloads
    // ------------------------------------------------------------

    // shared by aw and ar.
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic [prot_bits-1:0] prot;
    } addr_chan_t;

    typedef struct packed {
        logic [data_bits-1:0] data;
        logic [strb_bits-1:0] strb;
    } wdata_chan_t;

endpackage

// ==== logic/regmap_pkg.sv ====
// Register map of the slave: eight word registers, register 0 a fixed identity word.

package regmap_pkg;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------
    localparam int reg_count = 8;
    localparam int addr_unit = 4;                     // bytes per register.
    localparam int id_index  = 0;
    localparam logic [31:0] id_value = 32'h4a31_0001;

    // ------------------------------------------------------------
    // addressing
    // ------------------------------------------------------------

    // byte offset bits below the register index.
    localparam int idx_lsb = $clog2(addr_unit);

    // width of the index seen by the register file.
    localparam int idx_bits = $clog2(reg_count);

endpackage

// ==== logic/axi4l_if.sv ====
// AXI4-Lite signal bundle without clock or reset; those travel as separate ports.

`timescale 1ns/100ps

interface axi4l_if;

    // write address.
    logic [axi4l_pkg::addr_bits-1:0] awaddr;
    logic [axi4l_pkg::prot_bits-1:0] awprot;
    logic                            awvalid;
    logic                            awready;

    // write data.
    logic [axi4l_pkg::data_bits-1:0] wdata;
    logic [axi4l_pkg::strb_bits-1:0] wstrb;
    logic                            wvalid;
    logic                            wready;

    // write response.
    logic [axi4l_pkg::resp_bits-1:0] bresp;
    logic                            bvalid;
    logic                            bready;

    // read address.
    logic [axi4l_pkg::addr_bits-1:0] araddr;
    logic [axi4l_pkg::prot_bits-1:0] arprot;
    logic                            arvalid;
    logic                            arready;

    // read data.
    logic [axi4l_pkg::data_bits-1:0] rdata;
    logic [axi4l_pkg::resp_bits-1:0] rresp;
    logic                            rvalid;
    logic                            rready;

    modport master (
        output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
        output araddr, arprot, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
        input  araddr, arprot, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

// ==== logic/axi4l_channel_slice.sv ====
// One-entry valid/ready slice; output lags the input handshake by one cycle, full throughput.

`timescale 1ns/100ps

module axi4l_channel_slice #(
    parameter type payload_t = logic
) (
    input  logic     m_axi4l,
    input  logic     rst_n,

    // upstream side.
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_data,

    // downstream side.
    output logic     m_valid,
    input  logic     m_ready,
    output payload_t m_data
);

    // room when empty or when the held entry leaves this cycle.
    assign s_ready = !m_valid || m_ready;

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------
    always_ff @(posedge m_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------
    always_ff @(posedge m_axi4l) begin
        if (s_valid && s_ready) begin
            m_data <= s_data;                       // load on handshake only.
        end
    end

endmodule

// ==== logic/axi4l_access_master.sv ====
// Single-outstanding AXI4-Lite master; a cmd_valid seen while busy is dropped, prot is always zero.

`timescale 1ns/100ps

module axi4l_access_master (
    input  logic                            m_axi4l,
    input  logic                            rst_n,

    // command port.
    input  logic                            cmd_valid,
    input  logic                            cmd_write,
    input  logic [axi4l_pkg::addr_bits-1:0] cmd_addr,
    input  logic [axi4l_pkg::data_bits-1:0] cmd_wdata,
    input  logic [axi4l_pkg::strb_bits-1:0] cmd_strb,
    output logic                            busy,
    output logic                            done,
    output logic [axi4l_pkg::data_bits-1:0] rdata,
    output logic [axi4l_pkg::resp_bits-1:0] resp,

    axi4l_if.master                         bus
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,                                     // address and data phase.
        st_resp
    } state_t;

    state_t                          state;
    logic                            write_q;
    logic [axi4l_pkg::addr_bits-1:0] addr_q;
    logic [axi4l_pkg::data_bits-1:0] wdata_q;
    logic [axi4l_pkg::strb_bits-1:0] strb_q;
    logic                            aw_vld;
    logic                            w_vld;
    logic                            ar_vld;
    logic                            aw_left;
    logic                            w_left;
    logic                            ar_left;
    logic                            cmd_take;
    logic                            resp_hs;

    assign busy     = (state != st_idle);
    assign cmd_take = cmd_valid && !busy;

    // each request channel stays up until its own handshake.
    assign aw_left = aw_vld && !bus.awready;
    assign w_left  = w_vld  && !bus.wready;
    assign ar_left = ar_vld && !bus.arready;

    assign resp_hs = write_q ? (bus.bvalid && bus.bready) : (bus.rvalid && bus.rready);

    // ------------------------------------------------------------
    // bus drive
    // ------------------------------------------------------------
    assign bus.awaddr  = addr_q;
    assign bus.awprot  = '0;
    assign bus.awvalid = aw_vld;
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = strb_q;
    assign bus.wvalid  = w_vld;
    assign bus.araddr  = addr_q;
    assign bus.arprot  = '0;
    assign bus.arvalid = ar_vld;
    assign bus.bready  = (state == st_resp) && write_q;
    assign bus.rready  = (state == st_resp) && !write_q;

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    always_ff @(posedge m_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            write_q <= 1'b0;
            aw_vld  <= 1'b0;
            w_vld   <= 1'b0;
            ar_vld  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_take) begin
                        state   <= st_req;
                        write_q <= cmd_write;
                        aw_vld  <= cmd_write;
                        w_vld   <= cmd_write;
                        ar_vld  <= !cmd_write;
                    end
                end
                st_req: begin
                    aw_vld <= aw_left;
                    w_vld  <= w_left;
                    ar_vld <= ar_left;
                    if (!aw_left && !w_left && !ar_left) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (resp_hs) begin
                        state <= st_idle;
                        done  <= 1'b1;              // busy drops in the same cycle.
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ------------------------------------------------------------
    // command and response payload
    // ------------------------------------------------------------
    always_ff @(posedge m_axi4l) begin
        if (cmd_take) begin
            addr_q  <= cmd_addr;
            wdata_q <= cmd_wdata;
            strb_q  <= cmd_strb;
        end
        if (state == st_resp && resp_hs) begin
            rdata <= write_q ? '0 : bus.rdata;
            resp  <= write_q ? bus.bresp : bus.rresp;
        end
    end

endmodule

// ==== logic/axi4l_reg_slave.sv ====
// Register-file slave: reg 0 read-only identity, regs 1..7 byte-strobed; other accesses get SLVERR.

`timescale 1ns/100ps

module axi4l_reg_slave (
    input  logic   m_axi4l,
    input  logic   rst_n,
    axi4l_if.slave bus
);

    localparam int idx_w = axi4l_pkg::addr_bits - regmap_pkg::idx_lsb;

    axi4l_pkg::addr_chan_t           aw_in;
    axi4l_pkg::addr_chan_t           aw_out;
    axi4l_pkg::wdata_chan_t          w_in;
    axi4l_pkg::wdata_chan_t          w_out;
    axi4l_pkg::addr_chan_t           ar_in;
    axi4l_pkg::addr_chan_t           ar_out;
    logic                            aw_valid;
    logic                            w_valid;
    logic                            ar_valid;
    logic                            do_write;
    logic                            do_read;
    logic [idx_w-1:0]                wr_idx;
    logic [idx_w-1:0]                rd_idx;
    logic                            wr_ok;
    logic                            rd_ok;
    logic [axi4l_pkg::data_bits-1:0] rd_word;
    logic [axi4l_pkg::data_bits-1:0] regs [1:regmap_pkg::reg_count-1];

    // ------------------------------------------------------------
    // input slices
    // ------------------------------------------------------------
    assign aw_in = '{addr: bus.awaddr, prot: bus.awprot};
    assign w_in  = '{data: bus.wdata, strb: bus.wstrb};
    assign ar_in = '{addr: bus.araddr, prot: bus.arprot};

    axi4l_channel_slice #(.payload_t(axi4l_pkg::addr_chan_t)) aw_slice_i (
        .m_axi4l, .rst_n,
        .s_valid(bus.awvalid), .s_ready(bus.awready), .s_data(aw_in),
        .m_valid(aw_valid), .m_ready(do_write), .m_data(aw_out)
    );

    axi4l_channel_slice #(.payload_t(axi4l_pkg::wdata_chan_t)) w_slice_i (
        .m_axi4l, .rst_n,
        .s_valid(bus.wvalid), .s_ready(bus.wready), .s_data(w_in),
        .m_valid(w_valid), .m_ready(do_write), .m_data(w_out)
    );

    axi4l_channel_slice #(.payload_t(axi4l_pkg::addr_chan_t)) ar_slice_i (
        .m_axi4l, .rst_n,
        .s_valid(bus.arvalid), .s_ready(bus.arready), .s_data(ar_in),
        .m_valid(ar_valid), .m_ready(do_read), .m_data(ar_out)
    );

    // held entries stay in the slices while a response is pending.
    assign do_write = aw_valid && w_valid && !bus.bvalid;
    assign do_read  = ar_valid && !bus.rvalid && !do_write;    // write wins.

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign wr_idx = aw_out.addr[axi4l_pkg::addr_bits-1:regmap_pkg::idx_lsb];
    assign rd_idx = ar_out.addr[axi4l_pkg::addr_bits-1:regmap_pkg::idx_lsb];
    assign wr_ok  = (wr_idx < regmap_pkg::reg_count) && (wr_idx != regmap_pkg::id_index);
    assign rd_ok  = (rd_idx < regmap_pkg::reg_count);

    always_comb begin
        rd_word = '0;                               // out of map reads zero.
        if (rd_idx == regmap_pkg::id_index) begin
            rd_word = regmap_pkg::id_value;
        end
        for (int i = 1; i < regmap_pkg::reg_count; i++) begin
            if (rd_idx == i) begin
                rd_word = regs[i];
            end
        end
    end

    // ------------------------------------------------------------
    // register file
    // ------------------------------------------------------------
    always_ff @(posedge m_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < regmap_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write && wr_ok) begin
            for (int i = 1; i < regmap_pkg::reg_count; i++) begin
                for (int b = 0; b < axi4l_pkg::strb_bits; b++) begin
                    if (wr_idx == i && w_out.strb[b]) begin
                        regs[i][8*b +: 8] <= w_out.data[8*b +: 8];
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------
    // responses
    // ------------------------------------------------------------
    always_ff @(posedge m_axi4l or negedge rst_n) begin
        if (!rst_n) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (do_write) bus.bvalid <= 1'b1;
            else if (bus.bready) bus.bvalid <= 1'b0;
            if (do_read) bus.rvalid <= 1'b1;
            else if (bus.rready) bus.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge m_axi4l) begin
        if (do_write) begin
            bus.bresp <= wr_ok ? axi4l_pkg::resp_okay : axi4l_pkg::resp_slverr;
        end
        if (do_read) begin
            bus.rdata <= rd_word;
            bus.rresp <= rd_ok ? axi4l_pkg::resp_okay : axi4l_pkg::resp_slverr;
        end
    end

endmodule

// ==== logic/axi4l_reg_top.sv ====
// Command-driven register subsystem; one command at a time, completion is marked by done only.

`timescale 1ns/100ps

module axi4l_reg_top (
    input  logic                            m_axi4l,
    input  logic                            rst_n,

    // ------------------------------------------------------------
    // command port
    // ------------------------------------------------------------
    input  logic                            cmd_valid,
    input  logic                            cmd_write,
    input  logic [axi4l_pkg::addr_bits-1:0] cmd_addr,
    input  logic [axi4l_pkg::data_bits-1:0] cmd_wdata,
    input  logic [axi4l_pkg::strb_bits-1:0] cmd_strb,
    output logic                            busy,
    output logic                            done,
    output logic [axi4l_pkg::data_bits-1:0] rdata,
    output logic [axi4l_pkg::resp_bits-1:0] resp
);

    // internal AXI4-Lite link.
    axi4l_if bus_i ();

    axi4l_access_master master_i (
        .m_axi4l   (m_axi4l),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_strb  (cmd_strb),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .resp      (resp),
        .bus       (bus_i.master)
    );

    axi4l_reg_slave slave_i (
        .m_axi4l (m_axi4l),
        .rst_n   (rst_n),
        .bus     (bus_i.slave)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// Testbench clock of 20 ns and an active-low reset held for the first 5 rising edges.

`timescale 1ns/100ps

module tb_clock_gen (
    output logic m_axi4l,
    output logic rst_n
);

    localparam int half_period  = 10;
    localparam int reset_cycles = 5;

    initial begin
        m_axi4l = 1'b0;
        forever #(half_period) m_axi4l = ~m_axi4l;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge m_axi4l);
        #1 rst_n = 1'b1;                            // release off the edge.
    end

endmodule

// ==== sim/tb_axi4l_reg_top.sv ====
// Testbench for axi4l_reg_top; commands use word-aligned addresses only, one done per command.

`timescale 1ns/100ps

module tb_axi4l_reg_top;

    localparam int num_cmds    = 246;
    localparam int watchdog_ns = (num_cmds * 20 + 10) * 20;

    logic        m_axi4l;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_write;
    logic [11:0] cmd_addr;
    logic [31:0] cmd_wdata;
    logic [3:0]  cmd_strb;
    logic        busy;
    logic        done;
    logic [31:0] rdata;
    logic [1:0]  resp;

    logic [31:0] model [0:regmap_pkg::reg_count-1];
    logic [31:0] lfsr;
    int          errors;

    // expected results, oldest first.
    string       exp_name  [$];
    logic        exp_write [$];
    logic [31:0] exp_rdata [$];
    logic [1:0]  exp_resp  [$];

    tb_clock_gen clk_gen_i (.m_axi4l(m_axi4l), .rst_n(rst_n));

    axi4l_reg_top dut_i (
        .m_axi4l   (m_axi4l),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_write (cmd_write),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_strb  (cmd_strb),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .resp      (resp)
    );

    // ------------------------------------------------------------
    // random source and model
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32+x^22+x^2+x+1.
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = data[8*b +: 8];
        end
        return r;
    endfunction

    // expected {rdata, resp} for one command, taken before any write of it lands.
    function automatic logic [33:0] reference_result(input logic write, input logic [11:0] addr);
        int idx;
        idx = addr / regmap_pkg::addr_unit;
        if (idx >= regmap_pkg::reg_count) return {32'h0, axi4l_pkg::resp_slverr};
        if (write && idx == regmap_pkg::id_index) return {32'h0, axi4l_pkg::resp_slverr};
        if (write) return {32'h0, axi4l_pkg::resp_okay};
        if (idx == regmap_pkg::id_index) return {regmap_pkg::id_value, axi4l_pkg::resp_okay};
        return {model[idx], axi4l_pkg::resp_okay};
    endfunction

    function automatic void apply_write(input logic write, input logic [11:0] addr,
                                        input logic [31:0] data, input logic [3:0] strb);
        int idx;
        idx = addr / regmap_pkg::addr_unit;
        if (write && idx != regmap_pkg::id_index && idx < regmap_pkg::reg_count) begin
            model[idx] = merge_bytes(model[idx], data, strb);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------
    // command driving
    // ------------------------------------------------------------
    task automatic start_cmd(input string name, input logic write, input logic [11:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        logic [33:0] exp;
        while (busy) begin
            @(posedge m_axi4l);
            #1;
        end
        exp = reference_result(write, addr);
        exp_name.push_back(name);
        exp_write.push_back(write);
        exp_rdata.push_back(exp[33:2]);
        exp_resp.push_back(exp[1:0]);
        apply_write(write, addr, data, strb);
        cmd_valid = 1'b1;
        cmd_write = write;
        cmd_addr  = addr;
        cmd_wdata = data;
        cmd_strb  = strb;
        @(posedge m_axi4l);
        #1;
        cmd_valid = 1'b0;
        check_value({name, " busy"}, 32'd1, {31'd0, busy});
    endtask

    // busy must already be low in the done cycle.
    task automatic wait_done(input string name);
        while (!done) begin
            @(posedge m_axi4l);
            #1;
        end
        check_value({name, " busy at done"}, 32'd0, {31'd0, busy});
    endtask

    task automatic do_cmd(input string name, input logic write, input logic [11:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
        start_cmd(name, write, addr, data, strb);
        wait_done(name);                            // returns inside the done cycle.
    endtask

    // a write strobe the DUT must drop; the model stays as it is.
    task automatic pulse_while_busy(input logic [11:0] addr, input logic [31:0] data);
        if (busy) begin
            cmd_valid = 1'b1;
            cmd_write = 1'b1;
            cmd_addr  = addr;
            cmd_wdata = data;
            cmd_strb  = 4'hf;
            @(posedge m_axi4l);
            #1;
            cmd_valid = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // compare and watchdog
    // ------------------------------------------------------------
    always @(negedge m_axi4l) begin : compare_proc
        string name;
        if (rst_n && done) begin
            if (exp_name.size() == 0) begin
                $display("done pulsed with no command outstanding");
                $display("ERRORS FOUND");
                $fatal(1);
            end else begin
                name = exp_name.pop_front();
                check_value({name, " resp"}, {30'd0, exp_resp.pop_front()}, {30'd0, resp});
                if (!exp_write.pop_front()) check_value({name, " rdata"}, exp_rdata[0], rdata);
                void'(exp_rdata.pop_front());
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired, the DUT stopped answering commands");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        logic [31:0] d;
        logic [3:0]  s;
        logic [3:0]  idx;
        logic        w;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_strb  = '0;
        errors    = 0;
        lfsr      = 32'h8033ae26;
        for (int i = 0; i < regmap_pkg::reg_count; i++) model[i] = '0;
        @(posedge rst_n);
        @(posedge m_axi4l);
        #1;
        check_value("reset busy", 32'd0, {31'd0, busy});
        check_value("reset done", 32'd0, {31'd0, done});

        for (int i = 0; i < 8; i++) do_cmd("reset read", 1'b0, i * 4, '0, '0);

        for (int i = 1; i < 8; i++) begin
            d = take_bits(32);
            do_cmd("full write", 1'b1, i * 4, d, 4'hf);
            do_cmd("full readback", 1'b0, i * 4, '0, '0);
        end

        for (int i = 1; i < 8; i++) begin
            s = take_bits(4);
            d = take_bits(32);
            do_cmd("strobe write", 1'b1, i * 4, d, s);
            do_cmd("strobe readback", 1'b0, i * 4, '0, '0);
        end

        // identity and out-of-map accesses.
        do_cmd("id write", 1'b1, 12'h000, 32'hffff_ffff, 4'hf);
        do_cmd("map write", 1'b1, 12'h020, 32'h1234_5678, 4'hf);
        do_cmd("map read", 1'b0, 12'h020, '0, '0);
        do_cmd("far write", 1'b1, 12'hffc, 32'h0bad_0bad, 4'hf);
        do_cmd("far read", 1'b0, 12'hffc, '0, '0);
        do_cmd("id read", 1'b0, 12'h000, '0, '0);

        start_cmd("busy read", 1'b0, 12'h014, '0, '0);
        pulse_while_busy(12'h014, ~model[5]);
        wait_done("busy read");
        d = take_bits(32);
        start_cmd("busy write", 1'b1, 12'h018, d, 4'hf);
        pulse_while_busy(12'h018, ~d);
        wait_done("busy write");
        do_cmd("ignored check 5", 1'b0, 12'h014, '0, '0);
        do_cmd("ignored check 6", 1'b0, 12'h018, '0, '0);

        // back to back, indices 8..15 land out of the map.
        for (int n = 0; n < 200; n++) begin
            w   = take_bits(1);
            idx = take_bits(4);
            d   = take_bits(32);
            s   = take_bits(4);
            do_cmd($sformatf("random %0d", n), w, {6'd0, idx, 2'd0}, d, s);
        end

        @(negedge m_axi4l);
        #1;
        if (exp_name.size() != 0) begin
            $display("run ended with %0d responses never returned", exp_name.size());
            errors++;
        end
        if (errors == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

endmodule

// ==== filelist.f ====
logic/axi4l_pkg.sv
logic/regmap_pkg.sv
logic/axi4l_if.sv
logic/axi4l_channel_slice.sv
logic/axi4l_access_master.sv
logic/axi4l_reg_slave.sv
logic/axi4l_reg_top.sv
sim/tb_clock_gen.sv
sim/tb_axi4l_reg_top.sv
